/* hw/dmx_macros.svh */
// --------------------
// timing and size constants for the DMX512 transmitter
// bit rate, frame length, break length and CSR bus geometry
// --------------------

`ifndef DMX_MACROS_SVH
`define DMX_MACROS_SVH

// line timing
`define DMX_BAUD 250000 // DMX512 bit rate in bit/s
`define DMX_BREAK_BITS 25 // terminal value of the break counter

// channel memory
`define DMX_CHANNELS 512 // slots sent in every frame
`define DMX_CHAN_AW 9 // address width of the channel memory

// CSR bus
`define DMX_CSR_AW 14 // CSR address width
`define DMX_CSR_DW 32 // CSR data width
`define DMX_CSR_SEL_LSB 10 // lowest bit of the block select field

`endif

/* hw/dmx_csr_pkg.sv */
// --------------------
// register map types seen from the CSR bus
// address space selector and control register layout
// --------------------

package dmx_csr_pkg;

	// --------------------
	// address space inside the block, picked by the bit below the select field
	typedef enum logic {
		space_channels = 1'b0, // one byte per DMX slot
		space_control = 1'b1 // control register
	} csr_space_e;

	// --------------------
	// control register, bit 0 of the CSR word
	typedef struct packed {
		logic thru_en; // pass the thru input straight to tx
	} ctrl_reg_t;

endpackage

/* hw/dmx_frame_pkg.sv */
// --------------------
// frame generator types
// FSM state encoding and line source select
// --------------------

package dmx_frame_pkg;

	// states are listed in send order, so most steps are a plain increment
	typedef enum logic [4:0] {
		mtbp, // mark time between packets
		brk, // break, held low
		mab1, mab2, // mark after break
		sc_start, // start code, all low
		sc_d0, sc_d1, sc_d2, sc_d3,
		sc_d4, sc_d5, sc_d6, sc_d7,
		sc_stop1, sc_stop2,
		start, // slot start bit
		d0, d1, d2, d3, d4, d5, d6, d7, // slot data, LSB first
		stop1, stop2
	} frame_state_e;

	// source of the next bit on the line
	typedef enum logic [3:0] {
		sel_b0, sel_b1, sel_b2, sel_b3,
		sel_b4, sel_b5, sel_b6, sel_b7,
		sel_hi, // mark level
		sel_lo // space level
	} tx_sel_e;

endpackage

/* hw/dmx_chan_if.sv */
// --------------------
// host access port of the channel memory
// write strobe, address, write data and readback byte
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

interface dmx_chan_if;

	logic [`DMX_CHAN_AW-1:0] addr; // slot number
	logic we; // write strobe, one cycle per byte
	logic [7:0] wdata; // level to store
	logic [7:0] rdata; // level read back one cycle after addr

	// CSR side
	modport host (
		output addr, we, wdata,
		input rdata
	);

	// memory side
	modport mem (
		input addr, we, wdata,
		output rdata
	);

endinterface

/* hw/dmx_channel_ram.sv */
// --------------------
// 512 x 8 channel level memory
// host read/write port and a read only port for the frame generator
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

module dmx_channel_ram (
	input logic sys_clk,
	dmx_chan_if.mem chan,
	input logic [8:0] rd_addr,
	output logic [7:0] rd_data
);

	logic [7:0] mem [0:`DMX_CHANNELS-1]; // one level per slot

	// --------------------
	// host port, old data is returned when reading the address being written
	always_ff @(posedge sys_clk) begin
		if (chan.we) begin
			mem[chan.addr] <= chan.wdata;
		end
		chan.rdata <= mem[chan.addr];
	end

	// --------------------
	// generator port, read only
	always_ff @(posedge sys_clk) begin
		rd_data <= mem[rd_addr];
	end

	// the strobe comes from the CSR decode, an X there would corrupt levels silently
	a_we_known: assert property (
		@(posedge sys_clk) !$isunknown(chan.we)
	) else $error("channel memory write strobe is unknown");

endmodule

/* hw/dmx_csr_regs.sv */
// --------------------
// CSR decode for the DMX transmitter
// block select, channel write gating, control register, readback mux
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

module dmx_csr_regs import dmx_csr_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic [`DMX_CSR_AW-1:0] csr_a,
	input logic csr_we,
	input logic [`DMX_CSR_DW-1:0] csr_di,
	output logic [`DMX_CSR_DW-1:0] csr_do,
	dmx_chan_if.host chan,
	output logic thru_en
);

	logic csr_sel; // access targets this block
	csr_space_e space; // channel bytes or control register
	ctrl_reg_t ctrl;
	logic rd_chan; // last access read a channel byte
	logic [`DMX_CSR_DW-1:0] ctrl_do; // registered control readback

	// --------------------
	// address decode
	assign csr_sel = csr_a[`DMX_CSR_AW-1:`DMX_CSR_SEL_LSB] == csr_addr;
	assign space = csr_space_e'(csr_a[`DMX_CSR_SEL_LSB-1]);

	assign chan.addr = csr_a[`DMX_CHAN_AW-1:0];
	assign chan.wdata = csr_di[7:0];
	assign chan.we = csr_sel & csr_we & (space == space_channels);

	// --------------------
	// control register and read path
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ctrl <= '0;
			rd_chan <= 1'b0;
			ctrl_do <= '0;
		end else begin
			rd_chan <= csr_sel & (space == space_channels);
			ctrl_do <= '0; // unselected accesses read back zero
			if (csr_sel && space == space_control) begin
				ctrl_do <= {{(`DMX_CSR_DW-1){1'b0}}, ctrl.thru_en};
				if (csr_we) begin
					ctrl.thru_en <= csr_di[0];
				end
			end
		end
	end

	// memory data already lags its address by one cycle, like ctrl_do
	assign csr_do = rd_chan ? {{(`DMX_CSR_DW-8){1'b0}}, chan.rdata} : ctrl_do;

	assign thru_en = ctrl.thru_en;

	// a bus write to the channel space reaches the memory and leaves the control register alone
	a_chan_write: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		(csr_sel && csr_we && space == space_channels)
			|-> chan.we ##1 $stable(ctrl)
	) else $error("channel write lost or leaked into the control register");

endmodule

/* hw/dmx_bit_clock.sv */
// --------------------
// bit period clock enable
// one pulse of bit_ce per DMX bit time
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

module dmx_bit_clock #(
	parameter int clk_freq = 100000000
) (
	input logic sys_clk,
	input logic sys_rst,
	output logic bit_ce
);

	localparam int divisor = clk_freq / `DMX_BAUD; // clocks per bit
	localparam int cnt_w = (divisor > 1) ? $clog2(divisor) : 1;
	localparam logic [cnt_w-1:0] reload = cnt_w'(divisor - 1);

	logic [cnt_w-1:0] ce_cnt;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ce_cnt <= reload;
			bit_ce <= 1'b0;
		end else if (ce_cnt == '0) begin
			ce_cnt <= reload;
			bit_ce <= 1'b1; // terminal count
		end else begin
			ce_cnt <= ce_cnt - 1'b1;
			bit_ce <= 1'b0;
		end
	end

	a_ce_single: assert property (
		@(posedge sys_clk) disable iff (sys_rst) bit_ce |=> !bit_ce
	) else $error("bit_ce held for more than one cycle");

endmodule

/* hw/dmx_frame_gen.sv */
// --------------------
// DMX512 framing FSM
// break and slot counters, registered line mux, thru bypass
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

module dmx_frame_gen import dmx_frame_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic bit_ce,
	output logic [8:0] chan_addr,
	input logic [7:0] chan_data,
	input logic thru_en,
	input logic thru,
	output logic tx
);

	localparam logic [4:0] brk_last = 5'(`DMX_BREAK_BITS);
	localparam logic [`DMX_CHAN_AW-1:0] last_chan = `DMX_CHAN_AW'(`DMX_CHANNELS - 1);

	frame_state_e state;
	frame_state_e next_state;
	tx_sel_e tx_sel;

	logic brk_clr; // hold the break counter outside the break
	logic [4:0] brk_cnt;
	logic break_done;

	logic addr_clr; // slot address stays at zero until the first slot
	logic addr_inc;
	logic frame_done; // last slot has been addressed

	logic tx_gen; // registered line level from the FSM

	// --------------------
	// state register
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= mtbp;
		end else if (bit_ce) begin
			state <= next_state;
		end
	end

	assign brk_clr = state != brk;
	assign addr_clr = state < start; // covers mtbp through the start code
	assign addr_inc = state == stop1;

	always_comb begin
		next_state = frame_state_e'(state + 5'd1); // states are in send order
		tx_sel = sel_hi;
		case (state)
			brk: begin
				tx_sel = sel_lo;
				next_state = break_done ? mab1 : brk;
			end
			sc_start, sc_d0, sc_d1, sc_d2, sc_d3,
			sc_d4, sc_d5, sc_d6, sc_d7, start: tx_sel = sel_lo;
			d0: tx_sel = sel_b0;
			d1: tx_sel = sel_b1;
			d2: tx_sel = sel_b2;
			d3: tx_sel = sel_b3;
			d4: tx_sel = sel_b4;
			d5: tx_sel = sel_b5;
			d6: tx_sel = sel_b6;
			d7: tx_sel = sel_b7;
			stop2: next_state = frame_done ? mtbp : start;
			default: tx_sel = sel_hi; // mtbp, mab and stop bits stay at mark
		endcase
	end

	// --------------------
	// break length counter, break_done lands one bit after the terminal count
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brk_cnt <= '0;
			break_done <= 1'b0;
		end else if (bit_ce) begin
			if (brk_clr) begin
				brk_cnt <= '0;
				break_done <= 1'b0;
			end else if (brk_cnt == brk_last) begin
				break_done <= 1'b1;
			end else begin
				brk_cnt <= brk_cnt + 5'd1;
			end
		end
	end

	// --------------------
	// slot address, moves at stop1 so the next byte is ready before its start bit
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			chan_addr <= '0;
			frame_done <= 1'b0;
		end else if (bit_ce) begin
			if (addr_clr) begin
				chan_addr <= '0;
				frame_done <= 1'b0;
			end else if (addr_inc) begin
				chan_addr <= chan_addr + 1'b1; // wraps to zero after the last slot
				frame_done <= chan_addr == last_chan;
			end
		end
	end

	// --------------------
	// line output
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tx_gen <= 1'b1; // idle at mark
		end else begin
			case (tx_sel)
				sel_b0: tx_gen <= chan_data[0];
				sel_b1: tx_gen <= chan_data[1];
				sel_b2: tx_gen <= chan_data[2];
				sel_b3: tx_gen <= chan_data[3];
				sel_b4: tx_gen <= chan_data[4];
				sel_b5: tx_gen <= chan_data[5];
				sel_b6: tx_gen <= chan_data[6];
				sel_b7: tx_gen <= chan_data[7];
				sel_lo: tx_gen <= 1'b0;
				default: tx_gen <= 1'b1;
			endcase
		end
	end

	assign tx = thru_en ? thru : tx_gen; // bypass is not registered

	a_state_legal: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		!$isunknown(state) && state inside {[mtbp:stop2]}
	) else $error("frame FSM left its state set");

	// tx trails the state by one clock, hence the check on the next cycle
	a_stop_high: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		(!thru_en && state inside {stop1, stop2}) |=> (thru_en || tx)
	) else $error("stop bit driven low");

endmodule

/* hw/dmx_tx.sv */
// --------------------
// DMX512 transmitter top level
// CSR block, channel memory, bit clock and frame generator
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

module dmx_tx #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int clk_freq = 100000000
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic [`DMX_CSR_AW-1:0] csr_a,
	input logic csr_we,
	input logic [`DMX_CSR_DW-1:0] csr_di,
	output logic [`DMX_CSR_DW-1:0] csr_do,
	input logic thru,
	output logic tx
);

	logic thru_en;
	logic bit_ce;
	logic [8:0] chan_addr; // generator read address
	logic [7:0] chan_data;

	dmx_chan_if chan ();

	dmx_csr_regs #(
		.csr_addr(csr_addr)
	) i_csr (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.chan(chan.host),
		.thru_en(thru_en)
	);

	dmx_channel_ram i_ram (
		.sys_clk(sys_clk),
		.chan(chan.mem),
		.rd_addr(chan_addr),
		.rd_data(chan_data)
	);

	dmx_bit_clock #(
		.clk_freq(clk_freq)
	) i_bit_clock (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.bit_ce(bit_ce)
	);

	dmx_frame_gen i_frame_gen (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.bit_ce(bit_ce),
		.chan_addr(chan_addr),
		.chan_data(chan_data),
		.thru_en(thru_en),
		.thru(thru),
		.tx(tx)
	);

endmodule

/* tb/tb_dmx_tx.sv */
// --------------------
// testbench for the DMX512 transmitter
// CSR access tasks, mid-bit line decoder, reference levels
// concurrent checks for csr_do and the thru bypass
// --------------------

`timescale 1ns/1ps

`include "dmx_macros.svh"

module tb_dmx_tx;

	localparam logic [3:0] csr_blk = 4'h3;
	localparam int clk_freq = 2000000;
	localparam int bit_clks = clk_freq / `DMX_BAUD; // 8 clocks per bit
	// mtbp, break, mab, start code, then the slots
	localparam int frame_bits = 1 + 27 + 2 + 11 + 11 * `DMX_CHANNELS;
	localparam int timeout_cycles = 2 * frame_bits * bit_clks + 30000;
	localparam logic [13:0] idle_addr = 14'h0000; // block 0, never this DUT
	localparam logic [13:0] ctrl_addr = {csr_blk, 1'b1, 9'h000};

	logic sys_clk;
	logic sys_rst;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic thru;
	logic tx;

	logic [7:0] ref_mem [0:`DMX_CHANNELS-1]; // levels written by the testbench
	logic thru_check; // tx must follow thru while set
	int checks;
	int errors;
	int cycles;

	dmx_tx #(
		.csr_addr(csr_blk),
		.clk_freq(clk_freq)
	) i_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.thru(thru),
		.tx(tx)
	);

	always #4 sys_clk = ~sys_clk;

	// --------------------
	// bus and line helpers
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= addr;
		csr_we <= 1'b1;
		csr_di <= data;
		@(posedge sys_clk);
		csr_a <= idle_addr;
		csr_we <= 1'b0;
		csr_di <= '0;
	endtask

	task automatic csr_read(input logic [13:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= addr;
		@(posedge sys_clk);
		csr_a <= idle_addr;
		@(negedge sys_clk);
		data = csr_do; // registered reply of the access above
	endtask

	task automatic next_bit;
		repeat (bit_clks) @(negedge sys_clk);
	endtask

	task automatic wait_fall;
		logic prev;
		@(negedge sys_clk);
		prev = tx;
		@(negedge sys_clk);
		while (!(prev === 1'b1 && tx === 1'b0)) begin
			prev = tx;
			@(negedge sys_clk);
		end
		repeat (bit_clks / 2 - 1) @(negedge sys_clk); // move to the middle of the bit
	endtask

	// counts bits at one level, stops in the middle of the first other bit
	task automatic count_run(input logic level, output int run);
		run = 0;
		while (tx === level) begin
			run++;
			next_bit();
		end
	endtask

	// starts in the middle of the start bit, ends in the middle of the bit after stop2
	task automatic read_slot(output logic [7:0] value);
		check_value("tx start bit", tx, 1'b0);
		for (int i = 0; i < 8; i++) begin
			next_bit();
			value[i] = tx; // LSB first
		end
		next_bit();
		check_value("tx stop1", tx, 1'b1);
		next_bit();
		check_value("tx stop2", tx, 1'b1);
		next_bit();
	endtask

	task automatic check_frame;
		int run;
		logic [7:0] value;
		run = 0;
		while (run < 20) begin // slots and start code are never this long low
			wait_fall();
			count_run(1'b0, run);
		end
		check_value("break bit times", run, 27);
		count_run(1'b1, run);
		assert (run >= 2) else begin
			errors++;
			$display("mark after break lasted only %0d bit times at %0t", run, $time);
		end
		read_slot(value);
		check_value("start code", value, 8'h00);
		for (int i = 0; i < `DMX_CHANNELS; i++) begin
			read_slot(value);
			check_value($sformatf("slot %0d", i), value, ref_mem[i]);
		end
		check_value("tx mark before break", tx, 1'b1);
		next_bit();
		count_run(1'b0, run); // the break of the following frame
		check_value("break bit times", run, 27);
	endtask

	// --------------------
	// concurrent checks
	a_thru_copy: assert property (
		@(posedge sys_clk) disable iff (sys_rst) thru_check |-> tx === thru
	) else begin
		errors++;
		$display("FAIL %0t tx got %b expected %b", $time, $sampled(tx), $sampled(thru));
	end

	a_foreign_zero: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		csr_a[13:10] != csr_blk |=> csr_do == '0
	) else begin
		errors++;
		$display("FAIL %0t csr_do got %0h expected 0", $time, $sampled(csr_do));
	end

	// --------------------
	// test sequence
	initial begin : stimulus
		logic [31:0] rnd;
		logic [31:0] data;
		logic [8:0] ch;
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_a = idle_addr;
		csr_we = 1'b0;
		csr_di = '0;
		thru = 1'b0;
		thru_check = 1'b0;
		checks = 0;
		errors = 0;
		rnd = $urandom(32'h7ed8);
		repeat (2) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(negedge sys_clk);
		check_value("tx", tx, 1'b1);
		check_value("csr_do", csr_do, 32'h0);

		for (int i = 0; i < `DMX_CHANNELS; i++) begin
			rnd = $urandom;
			ref_mem[i] = rnd[7:0];
			csr_write({csr_blk, 1'b0, 9'(i)}, {rnd[31:8], rnd[7:0]}); // upper bits ignored
		end
		repeat (48) begin
			rnd = $urandom;
			ch = rnd[8:0];
			csr_read({csr_blk, 1'b0, ch}, data);
			check_value($sformatf("csr_do channel %0d", ch), data, {24'h0, ref_mem[ch]});
			csr_read({4'h5, 1'b0, ch}, data); // another block on the same bus
			check_value("csr_do other block", data, 32'h0);
		end

		csr_write(ctrl_addr, 32'h1);
		csr_read(ctrl_addr, data);
		check_value("thru_en", data, 32'h1);
		thru_check = 1'b1;
		repeat (256) begin
			@(posedge sys_clk);
			rnd = $urandom;
			thru <= rnd[0];
		end
		thru_check = 1'b0;
		csr_write(ctrl_addr, 32'h0);
		csr_read(ctrl_addr, data);
		check_value("thru_en", data, 32'h0);

		check_frame();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("timeout, the frame check did not finish within %0d cycles", timeout_cycles);
		$display("checks %0d, errors %0d", checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* dmx_tx.f */
+incdir+hw
hw/dmx_csr_pkg.sv
hw/dmx_frame_pkg.sv
hw/dmx_chan_if.sv
hw/dmx_channel_ram.sv
hw/dmx_csr_regs.sv
hw/dmx_bit_clock.sv
hw/dmx_frame_gen.sv
hw/dmx_tx.sv
tb/tb_dmx_tx.sv

/* Bender.yml */
package:
  name: dmx_tx

export_include_dirs:
  - hw

sources:
  - files:
      - hw/dmx_csr_pkg.sv
      - hw/dmx_frame_pkg.sv
      - hw/dmx_chan_if.sv
      - hw/dmx_channel_ram.sv
      - hw/dmx_csr_regs.sv
      - hw/dmx_bit_clock.sv
      - hw/dmx_frame_gen.sv
      - hw/dmx_tx.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_dmx_tx.sv
